/* src.f */
+incdir+src
src/rename_pkg.sv
src/free_list.sv
src/map_table.sv
src/dispatch_ctrl.sv
src/rob.sv
src/rename_top.sv
verification/rename_tb.sv

/* Makefile */
TOP := rename_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f src.f -o $(TOP)_sim
	@out="$$(./obj_dir/$(TOP)_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

/* verification/rename_tb.sv */
/* testbench for the rename and reorder subsystem
   shadow model of free FIFO, map and in-flight list, checked by concurrent assertions */

`timescale 1ns/1ps
`default_nettype none

`include "rename_defs.svh"

module rename_tb;

    localparam int N              = `RN_WIDTH;
    localparam int DEPTH          = `RN_ROB_DEPTH;
    localparam int ARCH           = `RN_ARCH_REGS;
    localparam int FREE_TAGS      = `RN_PHYS_REGS - `RN_ARCH_REGS;
    localparam int PERIOD         = 100;
    localparam int RESET_CYCLES   = 4;
    localparam int RANDOM_CYCLES  = 220;
    localparam int HOLD_CYCLES    = 40;
    localparam int DRAIN_LIMIT    = 116;
    // two random phases around the hold phase, then room to drain
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + 2 * RANDOM_CYCLES + HOLD_CYCLES + DRAIN_LIMIT;
    localparam int MODE_RANDOM    = 0;
    localparam int MODE_HOLD      = 1;
    localparam int MODE_DRAIN     = 2;

    // one instruction between dispatch and retirement
    typedef struct packed {
        logic                  done;
        rename_pkg::arch_idx_t dest;
        rename_pkg::phys_tag_t t;
        rename_pkg::phys_tag_t t_old;
    } flight_t;

    logic                                  clock;
    logic                                  reset;
    rename_pkg::way_count_t                credits;
    rename_pkg::way_count_t                dispatch_count;
    rename_pkg::arch_idx_t  [N-1:0]        dispatch_dest;
    rename_pkg::phys_tag_t  [N-1:0]        rename_t;
    rename_pkg::phys_tag_t  [N-1:0]        rename_t_old;
    logic                   [N-1:0]        complete_valid;
    rename_pkg::phys_tag_t  [N-1:0]        complete_t;
    rename_pkg::way_count_t                retire_count;
    rename_pkg::arch_idx_t  [N-1:0]        retire_dest;
    rename_pkg::phys_tag_t  [N-1:0]        retire_t;
    rename_pkg::phys_tag_t  [N-1:0]        retire_t_old;

    // expected outputs for the cycle being driven
    rename_pkg::way_count_t                exp_credits = '0;
    rename_pkg::phys_tag_t  [N-1:0]        exp_rename_t = '0;
    rename_pkg::phys_tag_t  [N-1:0]        exp_rename_t_old = '0;
    rename_pkg::way_count_t                exp_retire_count = '0;
    rename_pkg::arch_idx_t  [N-1:0]        exp_retire_dest = '0;
    rename_pkg::phys_tag_t  [N-1:0]        exp_retire_t = '0;
    rename_pkg::phys_tag_t  [N-1:0]        exp_retire_t_old = '0;

    // shadow model
    rename_pkg::phys_tag_t                 free_q [$];
    rename_pkg::phys_tag_t                 map [ARCH];
    flight_t                               inflight [$];

    int   mode = MODE_RANDOM;
    logic drained = 1'b0;
    logic starved_seen = 1'b0;
    logic restored_seen = 1'b0;
    int   errors = 0;
    int   dispatched = 0;
    int   completed = 0;
    int   retired = 0;
    logic seeded = 1'b0;

    rename_top i_dut (
        .clock          (clock),
        .reset          (reset),
        .credits        (credits),
        .dispatch_count (dispatch_count),
        .dispatch_dest  (dispatch_dest),
        .rename_t       (rename_t),
        .rename_t_old   (rename_t_old),
        .complete_valid (complete_valid),
        .complete_t     (complete_t),
        .retire_count   (retire_count),
        .retire_dest    (retire_dest),
        .retire_t       (retire_t),
        .retire_t_old   (retire_t_old)
    );

    always #(PERIOD / 2) clock = ~clock;

    // model update and stimulus, one step per rising edge
    always @(posedge clock) begin : model_step
        flight_t                        ent;
        int                             cap;
        int                             n;
        int                             nret;
        int                             k;
        int                             cand [$];
        rename_pkg::phys_tag_t  [N-1:0] ret_old;
        logic                   [N-1:0] cv;
        rename_pkg::phys_tag_t  [N-1:0] ct;
        rename_pkg::arch_idx_t  [N-1:0] dv;
        if (!seeded) begin
            // one seed for every draw below
            void'($urandom(55));
            seeded = 1'b1;
        end
        if (reset) begin
            free_q.delete();
            inflight.delete();
            // tags above the architectural range, ascending
            for (int t = 0; t < FREE_TAGS; t++) begin
                free_q.push_back(rename_pkg::phys_tag_t'(ARCH + t));
            end
            for (int r = 0; r < ARCH; r++) begin
                map[r] = rename_pkg::phys_tag_t'(r);
            end
            exp_credits      <= '0;
            exp_retire_count <= '0;
            dispatch_count   <= '0;
            complete_valid   <= '0;
        end else begin
            // grant for this cycle, from state after the last edge
            cap = N;
            if (free_q.size() < cap) begin
                cap = free_q.size();
            end
            if (DEPTH - inflight.size() < cap) begin
                cap = DEPTH - inflight.size();
            end
            exp_credits <= rename_pkg::way_count_t'(cap);
            if (mode == MODE_HOLD && cap == 0) begin
                starved_seen = 1'b1;
            end
            if (mode != MODE_HOLD && starved_seen && cap > 0) begin
                restored_seen = 1'b1;
            end

            // leading completed run retires, oldest first
            nret = 0;
            while (nret < N && nret < inflight.size() && inflight[nret].done) begin
                nret++;
            end
            ret_old = '0;
            for (int i = 0; i < nret; i++) begin
                ent = inflight.pop_front();
                exp_retire_dest[i]  <= ent.dest;
                exp_retire_t[i]     <= ent.t;
                exp_retire_t_old[i] <= ent.t_old;
                ret_old[i] = ent.t_old;
                retired++;
            end
            exp_retire_count <= rename_pkg::way_count_t'(nret);

            // completions picked from unfinished entries in random order
            cand.delete();
            for (int q = 0; q < inflight.size(); q++) begin
                if (!inflight[q].done) begin
                    cand.push_back(q);
                end
            end
            cv = '0;
            ct = '0;
            for (int j = 0; j < N; j++) begin
                if (mode != MODE_HOLD && cand.size() > 0
                        && (mode == MODE_DRAIN || $urandom % 2 == 1)) begin
                    k = $urandom % cand.size();
                    ent = inflight[cand[k]];
                    ent.done = 1'b1;
                    inflight[cand[k]] = ent;
                    cand.delete(k);
                    cv[j] = 1'b1;
                    ct[j] = ent.t;
                    completed++;
                end
            end
            complete_valid <= cv;
            complete_t     <= ct;

            // dispatch within the grant
            n = 0;
            if (mode != MODE_DRAIN && cap > 0) begin
                n = $urandom % (cap + 1);
            end
            for (int i = 0; i < N; i++) begin
                dv[i] = rename_pkg::arch_idx_t'($urandom % ARCH);
                // repeat a destination now and then to hit forwarding
                if (i > 0 && $urandom % 4 == 0) begin
                    dv[i] = dv[i - 1];
                end
                if (i < n) begin
                    ent.done  = 1'b0;
                    ent.dest  = dv[i];
                    ent.t     = free_q.pop_front();
                    ent.t_old = map[dv[i]];
                    map[dv[i]] = ent.t;
                    inflight.push_back(ent);
                    exp_rename_t[i]     <= ent.t;
                    exp_rename_t_old[i] <= ent.t_old;
                    dispatched++;
                end
            end
            dispatch_count <= rename_pkg::way_count_t'(n);
            dispatch_dest  <= dv;

            // retired t_old tags join the free FIFO behind the pops
            for (int i = 0; i < nret; i++) begin
                free_q.push_back(ret_old[i]);
            end
        end
        drained <= (inflight.size() == 0);
    end

    a_credits: assert property (@(posedge clock) disable iff (reset)
        credits == exp_credits)
    else begin
        errors++;
        $display("ERROR: credits got 0x%h expected 0x%h",
                 $sampled(credits), $sampled(exp_credits));
    end

    a_retire_count: assert property (@(posedge clock) disable iff (reset)
        retire_count == exp_retire_count)
    else begin
        errors++;
        $display("ERROR: retire_count got 0x%h expected 0x%h",
                 $sampled(retire_count), $sampled(exp_retire_count));
    end

    for (genvar i = 0; i < N; i++) begin : g_slot
        a_rename_t: assert property (@(posedge clock) disable iff (reset)
            (i < dispatch_count) |-> rename_t[i] == exp_rename_t[i])
        else begin
            errors++;
            $display("ERROR: rename_t[%0d] got 0x%h expected 0x%h",
                     i, $sampled(rename_t[i]), $sampled(exp_rename_t[i]));
        end

        a_rename_t_old: assert property (@(posedge clock) disable iff (reset)
            (i < dispatch_count) |-> rename_t_old[i] == exp_rename_t_old[i])
        else begin
            errors++;
            $display("ERROR: rename_t_old[%0d] got 0x%h expected 0x%h",
                     i, $sampled(rename_t_old[i]), $sampled(exp_rename_t_old[i]));
        end

        a_retire_dest: assert property (@(posedge clock) disable iff (reset)
            (i < exp_retire_count) |-> retire_dest[i] == exp_retire_dest[i])
        else begin
            errors++;
            $display("ERROR: retire_dest[%0d] got 0x%h expected 0x%h",
                     i, $sampled(retire_dest[i]), $sampled(exp_retire_dest[i]));
        end

        a_retire_t: assert property (@(posedge clock) disable iff (reset)
            (i < exp_retire_count) |-> retire_t[i] == exp_retire_t[i])
        else begin
            errors++;
            $display("ERROR: retire_t[%0d] got 0x%h expected 0x%h",
                     i, $sampled(retire_t[i]), $sampled(exp_retire_t[i]));
        end

        a_retire_t_old: assert property (@(posedge clock) disable iff (reset)
            (i < exp_retire_count) |-> retire_t_old[i] == exp_retire_t_old[i])
        else begin
            errors++;
            $display("ERROR: retire_t_old[%0d] got 0x%h expected 0x%h",
                     i, $sampled(retire_t_old[i]), $sampled(exp_retire_t_old[i]));
        end

        // no tag handed out twice in one group
        for (genvar j = 0; j < i; j++) begin : g_pair
            a_distinct: assert property (@(posedge clock) disable iff (reset)
                (i < dispatch_count) |-> rename_t[i] != rename_t[j])
            else begin
                errors++;
                $display("ERROR: rename_t[%0d] and rename_t[%0d] both 0x%h",
                         i, j, $sampled(rename_t[i]));
            end
        end
    end

    // phase sequencing
    initial begin
        clock          = 1'b0;
        reset          = 1'b1;
        dispatch_count = '0;
        dispatch_dest  = '0;
        complete_valid = '0;
        complete_t     = '0;
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;
        repeat (RANDOM_CYCLES) @(posedge clock);
        // completions held back until the free list runs dry
        mode <= MODE_HOLD;
        repeat (HOLD_CYCLES) @(posedge clock);
        mode <= MODE_RANDOM;
        repeat (RANDOM_CYCLES) @(posedge clock);
        mode <= MODE_DRAIN;
        @(posedge clock);
        while (!drained) begin
            @(posedge clock);
        end
        repeat (2) @(posedge clock);
        a_hold_reached: assert (starved_seen && restored_seen)
        else begin
            errors++;
            $display("credits did not drop to zero and recover around the hold phase");
        end
        $display("dispatched=%0d completed=%0d retired=%0d errors=%0d",
                 dispatched, completed, retired, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(TIMEOUT_CYCLES * PERIOD);
        $display("watchdog expired after %0d cycles, %0d instructions still in flight",
                 TIMEOUT_CYCLES, inflight.size());
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* src/rename_top.sv */
/* rename and reorder subsystem
   credit control, free list, rename map and ROB joined together */

`timescale 1ns/1ps
`default_nettype none

`include "rename_defs.svh"

module rename_top (
    input  wire logic                                      clock,
    input  wire logic                                      reset,
    output rename_pkg::way_count_t                         credits,
    input  wire rename_pkg::way_count_t                    dispatch_count,
    input  wire rename_pkg::arch_idx_t  [`RN_WIDTH-1:0]    dispatch_dest,
    output rename_pkg::phys_tag_t       [`RN_WIDTH-1:0]    rename_t,
    output rename_pkg::phys_tag_t       [`RN_WIDTH-1:0]    rename_t_old,
    input  wire logic                   [`RN_WIDTH-1:0]    complete_valid,
    input  wire rename_pkg::phys_tag_t  [`RN_WIDTH-1:0]    complete_t,
    output rename_pkg::way_count_t                         retire_count,
    output rename_pkg::arch_idx_t       [`RN_WIDTH-1:0]    retire_dest,
    output rename_pkg::phys_tag_t       [`RN_WIDTH-1:0]    retire_t,
    output rename_pkg::phys_tag_t       [`RN_WIDTH-1:0]    retire_t_old
);

    rename_pkg::way_count_t                  accept_count;
    rename_pkg::phys_tag_t  [`RN_WIDTH-1:0]  alloc_t;
    rename_pkg::phys_tag_t  [`RN_WIDTH-1:0]  old_t;
    rename_pkg::rob_count_t                  open_entries;
    rename_pkg::rob_count_t                  free_count;

    // rename results go straight out in the dispatch cycle
    assign rename_t     = alloc_t;
    assign rename_t_old = old_t;

    dispatch_ctrl i_dispatch_ctrl (
        .clock          (clock),
        .reset          (reset),
        .dispatch_count (dispatch_count),
        .open_entries   (open_entries),
        .free_count     (free_count),
        .accept_count   (accept_count),
        .credits        (credits)
    );

    // retired t_old tags recycle through the push side
    free_list i_free_list (
        .clock        (clock),
        .reset        (reset),
        .accept_count (accept_count),
        .alloc_t      (alloc_t),
        .push_count   (retire_count),
        .push_t       (retire_t_old),
        .free_count   (free_count)
    );

    map_table i_map_table (
        .clock        (clock),
        .reset        (reset),
        .accept_count (accept_count),
        .accept_dest  (dispatch_dest),
        .alloc_t      (alloc_t),
        .old_t        (old_t)
    );

    rob i_rob (
        .clock          (clock),
        .reset          (reset),
        .accept_count   (accept_count),
        .accept_dest    (dispatch_dest),
        .alloc_t        (alloc_t),
        .old_t          (old_t),
        .complete_valid (complete_valid),
        .complete_t     (complete_t),
        .open_entries   (open_entries),
        .retire_count   (retire_count),
        .retire_dest    (retire_dest),
        .retire_t       (retire_t),
        .retire_t_old   (retire_t_old)
    );

endmodule

`default_nettype wire

/* src/rob.sv */
/* N-way reorder buffer
   writes accepted instructions at the tail, marks completion by tag, retires in order */

`timescale 1ns/1ps
`default_nettype none

`include "rename_defs.svh"

module rob (
    input  wire logic                                      clock,
    input  wire logic                                      reset,
    input  wire rename_pkg::way_count_t                    accept_count,
    input  wire rename_pkg::arch_idx_t  [`RN_WIDTH-1:0]    accept_dest,
    input  wire rename_pkg::phys_tag_t  [`RN_WIDTH-1:0]    alloc_t,
    input  wire rename_pkg::phys_tag_t  [`RN_WIDTH-1:0]    old_t,
    input  wire logic                   [`RN_WIDTH-1:0]    complete_valid,
    input  wire rename_pkg::phys_tag_t  [`RN_WIDTH-1:0]    complete_t,
    output rename_pkg::rob_count_t                         open_entries,
    output rename_pkg::way_count_t                         retire_count,
    output rename_pkg::arch_idx_t       [`RN_WIDTH-1:0]    retire_dest,
    output rename_pkg::phys_tag_t       [`RN_WIDTH-1:0]    retire_t,
    output rename_pkg::phys_tag_t       [`RN_WIDTH-1:0]    retire_t_old
);

    localparam int N        = `RN_WIDTH;
    localparam int DEPTH    = `RN_ROB_DEPTH;
    localparam int PTR_BITS = $clog2(DEPTH);

    // head is the oldest entry, tail the next free slot
    logic [PTR_BITS-1:0]    head;
    logic [PTR_BITS-1:0]    tail;
    // occupancy tells full from empty when head == tail
    rename_pkg::rob_count_t used;

    rename_pkg::rob_entry_t entries      [DEPTH];
    rename_pkg::rob_entry_t next_entries [DEPTH];

    // retirement from registered state only
    always_comb begin
        logic                run;
        logic [PTR_BITS-1:0] idx;
        run          = 1'b1;
        retire_count = '0;
        retire_dest  = '0;
        retire_t     = '0;
        retire_t_old = '0;
        for (int i = 0; i < N; i++) begin
            idx = head + PTR_BITS'(i);
            // leading run of valid and complete entries only
            if (run && entries[idx].valid && entries[idx].complete) begin
                retire_dest[i]  = entries[idx].dest;
                retire_t[i]     = entries[idx].t;
                retire_t_old[i] = entries[idx].t_old;
                retire_count    = rename_pkg::way_count_t'(i + 1);
            end else begin
                run = 1'b0;
            end
        end
    end

    // free slots once this cycle's retire and accept have happened
    assign open_entries = rename_pkg::rob_count_t'(DEPTH) - used
                        + rename_pkg::rob_count_t'(retire_count)
                        - rename_pkg::rob_count_t'(accept_count);

    always_comb begin
        logic [PTR_BITS-1:0] idx;
        for (int k = 0; k < DEPTH; k++) begin
            next_entries[k] = entries[k];
        end
        // free the retiring slots
        for (int i = 0; i < N; i++) begin
            idx = head + PTR_BITS'(i);
            if (i < retire_count) begin
                next_entries[idx].valid    = 1'b0;
                next_entries[idx].complete = 1'b0;
            end
        end
        // completion broadcast, compared against every live entry
        for (int k = 0; k < DEPTH; k++) begin
            for (int j = 0; j < N; j++) begin
                if (complete_valid[j] && next_entries[k].valid
                        && entries[k].t == complete_t[j]) begin
                    next_entries[k].complete = 1'b1;
                end
            end
        end
        // new instructions land at the tail, slot 0 oldest
        for (int i = 0; i < N; i++) begin
            idx = tail + PTR_BITS'(i);
            if (i < accept_count) begin
                next_entries[idx].valid    = 1'b1;
                next_entries[idx].complete = 1'b0;
                next_entries[idx].dest     = accept_dest[i];
                next_entries[idx].t        = alloc_t[i];
                next_entries[idx].t_old    = old_t[i];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head <= '0;
            tail <= '0;
            used <= '0;
            // every entry starts empty
            for (int k = 0; k < DEPTH; k++) begin
                entries[k].valid    <= 1'b0;
                entries[k].complete <= 1'b0;
            end
        end else begin
            head <= head + PTR_BITS'(retire_count);
            tail <= tail + PTR_BITS'(accept_count);
            used <= used - rename_pkg::rob_count_t'(retire_count)
                  + rename_pkg::rob_count_t'(accept_count);
            for (int k = 0; k < DEPTH; k++) begin
                entries[k] <= next_entries[k];
            end
        end
    end

    // the front end must stay within the room left after retirement
    a_accept_fits: assert property (
        @(posedge clock) disable iff (reset)
        32'(accept_count) <= 32'(DEPTH) - 32'(used) + 32'(retire_count)
    ) else $error("rob overflow: accept_count=%0h used=%0h", accept_count, used);

endmodule

`default_nettype wire

/* src/dispatch_ctrl.sv */
/* dispatch credit control
   registers how many instructions the front end may send next cycle */

`timescale 1ns/1ps
`default_nettype none

`include "rename_defs.svh"

module dispatch_ctrl (
    input  wire logic                   clock,
    input  wire logic                   reset,
    input  wire rename_pkg::way_count_t dispatch_count,
    input  wire rename_pkg::rob_count_t open_entries,
    input  wire rename_pkg::rob_count_t free_count,
    output rename_pkg::way_count_t      accept_count,
    output rename_pkg::way_count_t      credits
);

    localparam int N = `RN_WIDTH;

    rename_pkg::way_count_t next_credits;

    // everything presented is taken, credits already bound it
    assign accept_count = dispatch_count;

    // min of width, ROB room and free tags, all after this cycle
    always_comb begin
        rename_pkg::rob_count_t limit;
        limit = rename_pkg::rob_count_t'(N);
        if (open_entries < limit) begin
            limit = open_entries;
        end
        if (free_count < limit) begin
            limit = free_count;
        end
        next_credits = rename_pkg::way_count_t'(limit);
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            // no credits until the first edge out of reset
            credits <= '0;
        end else begin
            credits <= next_credits;
        end
    end

    // front end must honour the grant from the previous edge
    a_within_credits: assert property (
        @(posedge clock) disable iff (reset)
        dispatch_count <= credits
    ) else $error("dispatch over credit: dispatch_count=%0h credits=%0h",
                  dispatch_count, credits);

endmodule

`default_nettype wire

/* src/map_table.sv */
/* speculative rename map
   looks up old tags with same-group forwarding, then applies updates in slot order */

`timescale 1ns/1ps
`default_nettype none

`include "rename_defs.svh"

module map_table (
    input  wire logic                                      clock,
    input  wire logic                                      reset,
    input  wire rename_pkg::way_count_t                    accept_count,
    input  wire rename_pkg::arch_idx_t  [`RN_WIDTH-1:0]    accept_dest,
    input  wire rename_pkg::phys_tag_t  [`RN_WIDTH-1:0]    alloc_t,
    output rename_pkg::phys_tag_t       [`RN_WIDTH-1:0]    old_t
);

    localparam int N    = `RN_WIDTH;
    localparam int REGS = `RN_ARCH_REGS;

    rename_pkg::phys_tag_t map [REGS];

    // old tag per slot
    // an older slot in the same group writing the same register wins,
    // and the nearest such slot overrides earlier ones
    always_comb begin
        for (int i = 0; i < N; i++) begin
            old_t[i] = map[accept_dest[i]];
            for (int j = 0; j < i; j++) begin
                if (j < accept_count && accept_dest[j] == accept_dest[i]) begin
                    old_t[i] = alloc_t[j];
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            // identity map, register r lives in tag r
            for (int r = 0; r < REGS; r++) begin
                map[r] <= rename_pkg::phys_tag_t'(r);
            end
        end else begin
            // later slots come last so the youngest write sticks
            for (int i = 0; i < N; i++) begin
                if (i < accept_count) begin
                    map[accept_dest[i]] <= alloc_t[i];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* src/free_list.sv */
/* free physical tag queue
   pops up to N new tags per cycle and takes back retired tags in slot order */

`timescale 1ns/1ps
`default_nettype none

`include "rename_defs.svh"

module free_list (
    input  wire logic                                      clock,
    input  wire logic                                      reset,
    input  wire rename_pkg::way_count_t                    accept_count,
    output rename_pkg::phys_tag_t       [`RN_WIDTH-1:0]    alloc_t,
    input  wire rename_pkg::way_count_t                    push_count,
    input  wire rename_pkg::phys_tag_t  [`RN_WIDTH-1:0]    push_t,
    output rename_pkg::rob_count_t                         free_count
);

    localparam int N         = `RN_WIDTH;
    // tags not held by the architectural map at reset
    localparam int FREE_TAGS = `RN_PHYS_REGS - `RN_ARCH_REGS;
    // rounded up so pointers wrap on their own
    localparam int DEPTH     = 1 << $clog2(FREE_TAGS);
    localparam int PTR_BITS  = $clog2(DEPTH);

    rename_pkg::phys_tag_t  fifo [DEPTH];
    logic [PTR_BITS-1:0]    head;
    logic [PTR_BITS-1:0]    tail;
    rename_pkg::rob_count_t count;

    // next tags handed out this cycle, slot 0 first
    always_comb begin
        for (int i = 0; i < N; i++) begin
            alloc_t[i] = fifo[head + PTR_BITS'(i)];
        end
    end

    // occupancy after this cycle's pops and pushes
    assign free_count = count
                      - rename_pkg::rob_count_t'(accept_count)
                      + rename_pkg::rob_count_t'(push_count);

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= PTR_BITS'(FREE_TAGS);
            count <= rename_pkg::rob_count_t'(FREE_TAGS);
            // tags above the architectural range, ascending
            for (int k = 0; k < DEPTH; k++) begin
                if (k < FREE_TAGS) begin
                    fifo[k] <= rename_pkg::phys_tag_t'(`RN_ARCH_REGS + k);
                end
            end
        end else begin
            // retired t_old values go in behind the existing tags
            for (int i = 0; i < N; i++) begin
                if (i < push_count) begin
                    fifo[tail + PTR_BITS'(i)] <= push_t[i];
                end
            end
            head  <= head + PTR_BITS'(accept_count);
            tail  <= tail + PTR_BITS'(push_count);
            count <= free_count;
        end
    end

    // credits derived from free_count must keep pops within stock
    a_no_underflow: assert property (
        @(posedge clock) disable iff (reset)
        rename_pkg::rob_count_t'(accept_count) <= count
    ) else $error("free list underflow: accept_count=%0h count=%0h", accept_count, count);

endmodule

`default_nettype wire

/* src/rename_pkg.sv */
/* shared types for the rename and reorder subsystem
   tags, register indices, counts and the ROB entry layout */

`include "rename_defs.svh"

`default_nettype none

package rename_pkg;

    // physical register tag, 6 bits for 44 registers
    typedef logic [$clog2(`RN_PHYS_REGS)-1:0] phys_tag_t;

    // architectural register index, 5 bits
    typedef logic [$clog2(`RN_ARCH_REGS)-1:0] arch_idx_t;

    // 0 .. N instructions in one cycle
    typedef logic [$clog2(`RN_WIDTH+1)-1:0] way_count_t;

    // 0 .. ROB depth, also wide enough for free list occupancy
    typedef logic [$clog2(`RN_ROB_DEPTH+1)-1:0] rob_count_t;

    // one in-flight instruction
    // t is the new tag, t_old the tag it displaced in the map
    typedef struct packed {
        logic      valid;
        logic      complete;
        arch_idx_t dest;
        phys_tag_t t;
        phys_tag_t t_old;
    } rob_entry_t;

endpackage

`default_nettype wire

/* src/rename_defs.svh */
/* rename and reorder subsystem sizing
   way count, ROB depth and register file sizes */

`ifndef RENAME_DEFS_SVH
`define RENAME_DEFS_SVH

// instructions renamed, accepted and retired per cycle
`define RN_WIDTH 2

// reorder buffer entries
`define RN_ROB_DEPTH 16

// architectural registers visible to software
`define RN_ARCH_REGS 32

// physical registers
// 44 - 32 leaves 12 free tags, so the free list runs dry
// before the ROB fills
`define RN_PHYS_REGS 44

`endif
